/* src/cmd_macros.svh */
// command port defaults
`ifndef CMD_MACROS_SVH
`define CMD_MACROS_SVH

// serial line rate and clk_wr frequency
`define DEF_BAUD      9600
`define DEF_SYS_CLK   50_000_000

// legal opcodes, ascii 'R' and 'W'
`define OP_READ       8'h52
`define OP_WRITE      8'h57

// register bank array
`define NUM_BANKS     4
`define BANK_WORDS    16

// returned for a read of a bank that does not exist
`define BAD_READ_WORD 32'hDEAD_BEEF

`endif

/* src/uart_pkg.sv */
// serial side types
package uart_pkg;

    // one received character with its strobe
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } rx_byte_t;

endpackage

/* src/cmd_pkg.sv */
// command and response types
package cmd_pkg;

    typedef logic [7:0] bank_idx_t;
    typedef logic [3:0] word_idx_t;

    typedef struct packed {
        logic [7:0]  op;
        logic [23:0] addr;
        logic [31:0] data;
    } cmd_fields_t;

    // first byte received lands in bytes[7], i.e. the opcode
    typedef union packed {
        logic [7:0][7:0] bytes;
        cmd_fields_t     fields;
    } cmd_frame_u;

    typedef struct packed {
        logic        strobe;
        logic [7:0]  op;
        logic [23:0] addr;
        logic [31:0] data;
    } cmd_t;

    typedef struct packed {
        logic        valid;
        logic [23:0] addr;
        logic [31:0] rdata;
    } rsp_t;

    function automatic bank_idx_t bank_of(input logic [23:0] addr);
        return addr[23:16];
    endfunction

    function automatic word_idx_t word_of(input logic [23:0] addr);
        return addr[3:0];
    endfunction

endpackage

/* src/uart_rx.sv */
// uart receiver
`timescale 1ns/1ps
`include "cmd_macros.svh"

module uart_rx #(
    parameter int BAUD    = `DEF_BAUD,
    parameter int SYS_CLK = `DEF_SYS_CLK
) (
    input  logic               clk_wr,
    input  logic               wr_rst_n,
    input  logic               rx_line,
    output uart_pkg::rx_byte_t rx_byte
);
    localparam int BIT_CYCLES = SYS_CLK / BAUD;
    localparam int CNT_W      = $clog2(BIT_CYCLES + 1);

    typedef enum logic [1:0] {S_IDLE, S_START, S_DATA, S_STOP} state_t;

    state_t           state;
    logic [2:0]       line_sync;
    logic [CNT_W-1:0] bit_cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       shreg;
    logic             byte_vld;
    logic             rx_s;
    logic             fall;
    logic             half_done;
    logic             bit_done;

    // two sync flops, third one only for edge detect
    assign rx_s      = line_sync[1];
    assign fall      = line_sync[2] & ~line_sync[1];
    assign half_done = (bit_cnt == CNT_W'(BIT_CYCLES / 2 - 1));
    assign bit_done  = (bit_cnt == CNT_W'(BIT_CYCLES - 1));

    always_ff @(posedge clk_wr or negedge wr_rst_n) begin
        if (!wr_rst_n) begin
            line_sync <= 3'b111;
            state     <= S_IDLE;
            bit_cnt   <= '0;
            bit_idx   <= '0;
            byte_vld  <= 1'b0;
        end else begin
            line_sync <= {line_sync[1:0], rx_line};
            byte_vld  <= 1'b0;
            case (state)
                S_IDLE: begin
                    bit_cnt <= '0;
                    if (fall) begin
                        state <= S_START;
                    end
                end
                S_START: begin
                    // middle of start bit, line must still be low
                    if (half_done) begin
                        bit_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rx_s ? S_IDLE : S_DATA;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                S_DATA: begin
                    if (bit_done) begin
                        bit_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= S_STOP;
                        end
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                S_STOP: begin
                    if (bit_done) begin
                        // bad stop bit drops the byte
                        byte_vld <= rx_s;
                        state    <= S_IDLE;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // lsb first
    always_ff @(posedge clk_wr) begin
        if (state == S_DATA && bit_done) begin
            shreg <= {rx_s, shreg[7:1]};
        end
    end

    assign rx_byte = '{valid: byte_vld, data: shreg};

endmodule

/* src/async_byte_fifo.sv */
// dual clock byte fifo
`timescale 1ns/1ps

module async_byte_fifo (
    input  logic               clk_wr,
    input  logic               wr_rst_n,
    input  logic               clk_rd,
    input  logic               rd_rst_n,
    input  uart_pkg::rx_byte_t wr_byte,
    input  logic               rd_req,
    output logic [7:0]         q,
    output logic               full
);
    localparam int AW = 3;

    logic [7:0]  mem [2**AW];
    logic [AW:0] wptr_bin;
    logic [AW:0] wptr_gray;
    logic [AW:0] wptr_bin_nxt;
    logic [AW:0] rptr_bin;
    logic [AW:0] rptr_gray;
    logic [AW:0] rptr_bin_nxt;
    logic [AW:0] rptr_gray_w1;
    logic [AW:0] rptr_gray_w2;
    logic [AW:0] wptr_gray_r1;
    logic [AW:0] wptr_gray_r2;
    logic        wr_full;
    logic        wr_en;
    logic        empty;
    logic        rd_en;

    function automatic logic [AW:0] bin2gray(input logic [AW:0] b);
        return b ^ (b >> 1);
    endfunction

    // write side
    assign wptr_bin_nxt = wptr_bin + 1'b1;
    assign wr_full = (wptr_gray == {~rptr_gray_w2[AW:AW-1], rptr_gray_w2[AW-2:0]});
    assign wr_en   = wr_byte.valid & ~wr_full;

    always_ff @(posedge clk_wr or negedge wr_rst_n) begin
        if (!wr_rst_n) begin
            wptr_bin     <= '0;
            wptr_gray    <= '0;
            rptr_gray_w1 <= '0;
            rptr_gray_w2 <= '0;
        end else begin
            rptr_gray_w1 <= rptr_gray;
            rptr_gray_w2 <= rptr_gray_w1;
            if (wr_en) begin
                wptr_bin  <= wptr_bin_nxt;
                wptr_gray <= bin2gray(wptr_bin_nxt);
            end
        end
    end

    always_ff @(posedge clk_wr) begin
        if (wr_en) begin
            mem[wptr_bin[AW-1:0]] <= wr_byte.data;
        end
    end

    // read side
    assign rptr_bin_nxt = rptr_bin + 1'b1;
    assign empty = (rptr_gray == wptr_gray_r2);
    assign full  = (rptr_gray == {~wptr_gray_r2[AW:AW-1], wptr_gray_r2[AW-2:0]});
    assign rd_en = rd_req & ~empty;

    always_ff @(posedge clk_rd or negedge rd_rst_n) begin
        if (!rd_rst_n) begin
            rptr_bin     <= '0;
            rptr_gray    <= '0;
            wptr_gray_r1 <= '0;
            wptr_gray_r2 <= '0;
        end else begin
            wptr_gray_r1 <= wptr_gray;
            wptr_gray_r2 <= wptr_gray_r1;
            if (rd_en) begin
                rptr_bin  <= rptr_bin_nxt;
                rptr_gray <= bin2gray(rptr_bin_nxt);
            end
        end
    end

    // q valid the cycle after rd_req
    always_ff @(posedge clk_rd) begin
        if (rd_en) begin
            q <= mem[rptr_bin[AW-1:0]];
        end
    end

endmodule

/* src/rx_fsm.sv */
// frame assembler
`timescale 1ns/1ps
`include "cmd_macros.svh"

module rx_fsm (
    input  logic          clk_rd,
    input  logic          rd_rst_n,
    input  logic          full,
    input  logic [7:0]    q,
    output logic          rd_req,
    output cmd_pkg::cmd_t cmd
);
    import cmd_pkg::*;

    typedef enum logic [1:0] {S_IDLE, S_FETCH, S_DECODE} state_t;

    state_t     state;
    logic [3:0] rd_cnt;
    logic       q_vld;
    cmd_frame_u frame;
    logic       op_legal;

    always_ff @(posedge clk_rd or negedge rd_rst_n) begin
        if (!rd_rst_n) begin
            state  <= S_IDLE;
            rd_req <= 1'b0;
            rd_cnt <= '0;
            q_vld  <= 1'b0;
        end else begin
            q_vld <= rd_req;
            case (state)
                S_IDLE: begin
                    if (full) begin
                        state  <= S_FETCH;
                        rd_req <= 1'b1;
                        rd_cnt <= '0;
                    end
                end
                S_FETCH: begin
                    rd_cnt <= rd_cnt + 1'b1;
                    // eight reads, then one more cycle for the last q
                    if (rd_cnt == 4'd7) begin
                        rd_req <= 1'b0;
                    end
                    if (rd_cnt == 4'd8) begin
                        state <= S_DECODE;
                    end
                end
                S_DECODE: begin
                    state <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // oldest byte ends up in the top byte
    always_ff @(posedge clk_rd) begin
        if (q_vld) begin
            frame.bytes <= {frame.bytes[6:0], q};
        end
    end

    assign op_legal = (frame.fields.op == `OP_READ) || (frame.fields.op == `OP_WRITE);

    // illegal opcodes never strobe
    assign cmd = '{
        strobe: (state == S_DECODE) && op_legal,
        op:     frame.fields.op,
        addr:   frame.fields.addr,
        data:   frame.fields.data
    };

endmodule

/* src/reg_bank.sv */
// register bank
`timescale 1ns/1ps
`include "cmd_macros.svh"

module reg_bank #(
    parameter int BANK_ID = 0
) (
    input  logic          clk_rd,
    input  logic          rd_rst_n,
    input  cmd_pkg::cmd_t cmd,
    output logic          hit,
    output logic [31:0]   rdata
);
    import cmd_pkg::*;

    logic [31:0] regs [`BANK_WORDS];
    logic        sel;
    logic        rd_sel;
    word_idx_t   widx;

    assign sel    = cmd.strobe && (bank_of(cmd.addr) == bank_idx_t'(BANK_ID));
    assign rd_sel = sel && (cmd.op == `OP_READ);
    assign widx   = word_of(cmd.addr);

    always_ff @(posedge clk_rd or negedge rd_rst_n) begin
        if (!rd_rst_n) begin
            hit <= 1'b0;
            for (int i = 0; i < `BANK_WORDS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            hit <= rd_sel;
            if (sel && cmd.op == `OP_WRITE) begin
                regs[widx] <= cmd.data;
            end
        end
    end

    always_ff @(posedge clk_rd) begin
        if (rd_sel) begin
            rdata <= regs[widx];
        end
    end

endmodule

/* src/rsp_collect.sv */
// response collector
`timescale 1ns/1ps
`include "cmd_macros.svh"

module rsp_collect (
    input  logic                  clk_rd,
    input  logic                  rd_rst_n,
    input  cmd_pkg::cmd_t         cmd,
    input  logic [`NUM_BANKS-1:0] hit,
    input  logic [31:0]           rdata [`NUM_BANKS],
    output cmd_pkg::rsp_t         rsp
);
    logic        rd_pend;
    logic [23:0] pend_addr;
    logic [31:0] hit_data;
    logic        rsp_vld;
    logic [23:0] rsp_addr;
    logic [31:0] rsp_data;

    // at most one bank hits
    always_comb begin
        hit_data = '0;
        for (int b = 0; b < `NUM_BANKS; b++) begin
            if (hit[b]) begin
                hit_data = hit_data | rdata[b];
            end
        end
    end

    always_ff @(posedge clk_rd or negedge rd_rst_n) begin
        if (!rd_rst_n) begin
            rd_pend <= 1'b0;
            rsp_vld <= 1'b0;
        end else begin
            rd_pend <= cmd.strobe && (cmd.op == `OP_READ);
            rsp_vld <= rd_pend;
        end
    end

    always_ff @(posedge clk_rd) begin
        if (cmd.strobe) begin
            pend_addr <= cmd.addr;
        end
        if (rd_pend) begin
            rsp_addr <= pend_addr;
            rsp_data <= (|hit) ? hit_data : `BAD_READ_WORD;
        end
    end

    assign rsp = '{valid: rsp_vld, addr: rsp_addr, rdata: rsp_data};

endmodule

/* src/uart_cmd_top.sv */
// serial command port top
`timescale 1ns/1ps
`include "cmd_macros.svh"

module uart_cmd_top #(
    parameter int BAUD    = `DEF_BAUD,
    parameter int SYS_CLK = `DEF_SYS_CLK
) (
    input  logic          clk_wr,
    input  logic          clk_rd,
    input  logic          wr_rst_n,
    input  logic          rd_rst_n,
    input  logic          rx_line,
    output cmd_pkg::rsp_t rsp
);
    import uart_pkg::*;
    import cmd_pkg::*;

    rx_byte_t              rx_byte;
    logic [7:0]            fifo_q;
    logic                  fifo_full;
    logic                  rd_req;
    cmd_t                  cmd;
    logic [`NUM_BANKS-1:0] bank_hit;
    logic [31:0]           bank_rdata [`NUM_BANKS];

    uart_rx #(
        .BAUD    (BAUD),
        .SYS_CLK (SYS_CLK)
    ) i_uart_rx (
        .clk_wr   (clk_wr),
        .wr_rst_n (wr_rst_n),
        .rx_line  (rx_line),
        .rx_byte  (rx_byte)
    );

    async_byte_fifo i_fifo (
        .clk_wr   (clk_wr),
        .wr_rst_n (wr_rst_n),
        .clk_rd   (clk_rd),
        .rd_rst_n (rd_rst_n),
        .wr_byte  (rx_byte),
        .rd_req   (rd_req),
        .q        (fifo_q),
        .full     (fifo_full)
    );

    rx_fsm i_rx_fsm (
        .clk_rd   (clk_rd),
        .rd_rst_n (rd_rst_n),
        .full     (fifo_full),
        .q        (fifo_q),
        .rd_req   (rd_req),
        .cmd      (cmd)
    );

    // each bank answers to its own index in addr[23:16]
    for (genvar g = 0; g < `NUM_BANKS; g++) begin : g_bank
        reg_bank #(
            .BANK_ID (g)
        ) i_bank (
            .clk_rd   (clk_rd),
            .rd_rst_n (rd_rst_n),
            .cmd      (cmd),
            .hit      (bank_hit[g]),
            .rdata    (bank_rdata[g])
        );
    end

    rsp_collect i_rsp_collect (
        .clk_rd   (clk_rd),
        .rd_rst_n (rd_rst_n),
        .cmd      (cmd),
        .hit      (bank_hit),
        .rdata    (bank_rdata),
        .rsp      (rsp)
    );

endmodule

/* test/tb_uart_cmd.sv */
// command port testbench
`timescale 1ns/1ps

module tb_uart_cmd;
    import cmd_pkg::*;

    localparam int SYS_CLK   = 1_000_000;
    localparam int BAUD      = 100_000;
    localparam int BIT_CLKS  = SYS_CLK / BAUD;
    localparam int MAX_CMDS  = 64;
    localparam int COLS      = 5;
    localparam int DRAIN_MAX = 500;
    localparam int QUIET     = 200;

    logic        clk_wr;
    logic        clk_rd;
    logic        wr_rst_n;
    logic        rd_rst_n;
    logic        rx_line;
    rsp_t        rsp;

    // columns per command: op, addr, data, rsp flag, expected rdata
    logic [31:0] stim_mem [MAX_CMDS*COLS];
    logic [23:0] exp_addr_q [$];
    logic [31:0] exp_data_q [$];
    int          exp_idx_q [$];
    integer      seed;
    int          num_cmds;
    int          num_rsp;
    int          mismatches;
    int          other_errs;

    uart_cmd_top #(
        .BAUD    (BAUD),
        .SYS_CLK (SYS_CLK)
    ) i_uart_cmd_top (
        .clk_wr   (clk_wr),
        .clk_rd   (clk_rd),
        .wr_rst_n (wr_rst_n),
        .rd_rst_n (rd_rst_n),
        .rx_line  (rx_line),
        .rsp      (rsp)
    );

    initial begin
        clk_rd = 1'b0;
        forever #20 clk_rd = ~clk_rd;
    end

    initial begin
        clk_wr = 1'b0;
        forever #15 clk_wr = ~clk_wr;
    end

    task automatic load_stimulus();
        for (int i = 0; i < MAX_CMDS * COLS; i++) begin
            stim_mem[i] = 32'hffff_0000 | i;
        end
        $readmemh("test/stim_cmds.txt", stim_mem);
        // an op word with upper bits set marks the end of the file
        num_cmds = 0;
        while (num_cmds < MAX_CMDS && stim_mem[num_cmds*COLS][31:8] == 24'h0) begin
            num_cmds++;
        end
        assert (num_cmds > 0) else begin
            $display("no commands could be read from test/stim_cmds.txt");
            other_errs++;
        end
    endtask

    // one bit time, starting on a falling clk_wr edge
    task automatic hold_bit(input logic v);
        rx_line = v;
        repeat (BIT_CLKS) @(negedge clk_wr);
    endtask

    task automatic send_byte(input logic [7:0] b);
        hold_bit(1'b0);
        for (int i = 0; i < 8; i++) begin
            hold_bit(b[i]);
        end
        hold_bit(1'b1);
    endtask

    // op byte goes out first, then addr and data msb first
    task automatic send_frame(input logic [63:0] frame);
        int gap;
        for (int k = 7; k >= 0; k--) begin
            send_byte(frame[k*8 +: 8]);
            gap = $unsigned($random(seed)) % 4;
            repeat (gap) hold_bit(1'b1);
        end
    endtask

    task automatic check_response(input logic [23:0] addr, input logic [31:0] rdata);
        logic [23:0] e_addr;
        logic [31:0] e_data;
        int          idx;
        num_rsp++;
        assert (exp_addr_q.size() > 0) else begin
            $display("unexpected response with address %06h and data %08h", addr, rdata);
            other_errs++;
        end
        if (exp_addr_q.size() > 0) begin
            e_addr = exp_addr_q.pop_front();
            e_data = exp_data_q.pop_front();
            idx    = exp_idx_q.pop_front();
            assert (addr == e_addr) else begin
                $display("Mismatch cmd%0d addr: expected %06h, actual %06h", idx, e_addr, addr);
                mismatches++;
            end
            assert (rdata == e_data) else begin
                $display("Mismatch cmd%0d rdata: expected %08h, actual %08h",
                         idx, e_data, rdata);
                mismatches++;
            end
        end
    endtask

    task automatic wait_for_drain();
        int cycles;
        cycles = 0;
        while (exp_addr_q.size() > 0 && cycles < DRAIN_MAX) begin
            @(negedge clk_rd);
            cycles++;
        end
        assert (exp_addr_q.size() == 0) else begin
            $display("timed out waiting for %0d outstanding responses", exp_addr_q.size());
            other_errs++;
        end
    endtask

    // rsp is a one-cycle pulse, sampled away from the rising edge
    always @(negedge clk_rd) begin
        if (rd_rst_n && rsp.valid) begin
            check_response(rsp.addr, rsp.rdata);
        end
    end

    initial begin
        int          base;
        logic [63:0] frame;
        wr_rst_n   = 1'b0;
        rd_rst_n   = 1'b0;
        rx_line    = 1'b1;
        seed       = 32'hb3c0;
        num_cmds   = 0;
        num_rsp    = 0;
        mismatches = 0;
        other_errs = 0;
        load_stimulus();

        repeat (5) @(posedge clk_rd);
        @(negedge clk_rd);
        rd_rst_n = 1'b1;
        @(negedge clk_wr);
        wr_rst_n = 1'b1;
        repeat (2) hold_bit(1'b1);

        for (int i = 0; i < num_cmds; i++) begin
            base  = i * COLS;
            frame = {stim_mem[base][7:0], stim_mem[base+1][23:0], stim_mem[base+2]};
            // expectation is queued before the frame goes out
            if (stim_mem[base+3][0]) begin
                exp_addr_q.push_back(stim_mem[base+1][23:0]);
                exp_data_q.push_back(stim_mem[base+4]);
                exp_idx_q.push_back(i);
            end
            send_frame(frame);
        end

        wait_for_drain();
        // stray responses would show up here
        repeat (QUIET) @(negedge clk_rd);

        $display("summary: %0d commands, %0d responses, %0d mismatches, %0d other errors",
                 num_cmds, num_rsp, mismatches, other_errs);
        if (mismatches == 0 && other_errs == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* test/stim_cmds.txt */
// op addr data rsp exp_rdata, all hex
// op 52 is a read and 57 a write, rsp is 1 where a response is expected
52 000003 00000000 1 00000000
57 000003 11112222 0 00000000
52 000003 00000000 1 11112222
57 010005 a5a5a5a5 0 00000000
52 010005 00000000 1 a5a5a5a5
57 02000f 12345678 0 00000000
52 02000f 00000000 1 12345678
57 030000 cafef00d 0 00000000
52 030000 00000000 1 cafef00d
52 030001 00000000 1 00000000
52 02000e 00000000 1 00000000
13 000003 ffffffff 0 00000000
52 000003 00000000 1 11112222
52 040002 00000000 1 deadbeef
52 ff0007 00000000 1 deadbeef
57 010006 0badf00d 0 00000000
52 010006 00000000 1 0badf00d
52 010005 00000000 1 a5a5a5a5

/* sources.f */
+incdir+src
src/uart_pkg.sv
src/cmd_pkg.sv
src/uart_rx.sv
src/async_byte_fifo.sv
src/rx_fsm.sv
src/reg_bank.sv
src/rsp_collect.sv
src/uart_cmd_top.sv
test/tb_uart_cmd.sv

/* Makefile */
# Verilator build and run for the serial command port

VERILATOR ?= verilator
TOP       ?= tb_uart_cmd
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TESTBENCH PASSED
VFLAGS    ?= --binary --timing --assert

EXE := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	./$(EXE) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
